// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // csr numbers handled by this unit
    typedef enum logic [13:0] {
        CRMD   = 14'h00,
        PRMD   = 14'h01,
        ECFG   = 14'h04,
        ESTAT  = 14'h05,
        ERA    = 14'h06,
        EENTRY = 14'h0C,
        CPUID  = 14'h20,
        SAVE0  = 14'h30,
        SAVE1  = 14'h31,
        SAVE2  = 14'h32,
        SAVE3  = 14'h33
    } csr_addr_e;

    // exception codes seen on excp_req
    typedef enum logic [5:0] {
        INT = 6'h00,
        SYS = 6'h0B,
        BRK = 6'h0C,
        INE = 6'h0D
    } ecode_e;

    // ones over bits hi:lo
    function automatic logic [31:0] field_mask(input int hi, input int lo);
        return ((32'h1 << (hi - lo + 1)) - 32'h1) << lo;
    endfunction

    // crmd fields
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7;
    localparam int CRMD_DATM_HI = 8;

    // prmd fields
    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_HI = 1;
    localparam int PRMD_PIE     = 2;

    // ecfg lie is 12:0 architecturally but only 9:0 is kept here
    localparam int ECFG_LIE_LO    = 0;
    localparam int ECFG_LIE_WR_HI = 9;

    // estat fields
    localparam int ESTAT_IS_SW_LO    = 0;
    localparam int ESTAT_IS_SW_HI    = 1;
    localparam int ESTAT_IS_HW_LO    = 2;
    localparam int ESTAT_IS_HW_HI    = 9;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ECODE_HI    = 21;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_HI = 30;

    // eentry handler base
    localparam int EENTRY_VA_LO = 6;
    localparam int EENTRY_VA_HI = 31;

    // writable bits per register
    localparam logic [31:0] CRMD_WMASK = field_mask(CRMD_PLV_HI, CRMD_PLV_LO)
        | field_mask(CRMD_IE, CRMD_IE) | field_mask(CRMD_DA, CRMD_DA)
        | field_mask(CRMD_PG, CRMD_PG) | field_mask(CRMD_DATF_HI, CRMD_DATF_LO)
        | field_mask(CRMD_DATM_HI, CRMD_DATM_LO);
    localparam logic [31:0] PRMD_WMASK = field_mask(PRMD_PPLV_HI, PRMD_PPLV_LO)
        | field_mask(PRMD_PIE, PRMD_PIE);
    localparam logic [31:0] ECFG_WMASK   = field_mask(ECFG_LIE_WR_HI, ECFG_LIE_LO);
    localparam logic [31:0] EENTRY_WMASK = field_mask(EENTRY_VA_HI, EENTRY_VA_LO);

    // direct address translation on out of reset
    localparam logic [31:0] CRMD_RESET = 32'h1 << CRMD_DA;

    typedef struct packed {
        logic        wr_en;
        logic [13:0] waddr;
        logic [31:0] wdata;
        logic [13:0] raddr;
    } csr_req_t;

    typedef struct packed {
        logic        valid;
        ecode_e      ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
    } excp_req_t;

    typedef struct packed {
        logic        excp;
        logic        ertn;
        logic [31:0] era;
        ecode_e      ecode;
        logic [8:0]  esubcode;
    } flush_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

// ==== design/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_req_t    csr_req,
    input  flush_t      flush,
    input  logic [7:0]  hw_is,
    output logic [31:0] rdata,
    output logic [1:0]  plv,
    output logic [31:0] eentry,
    output logic [31:0] era,
    output logic        ie,
    output logic [9:0]  is,
    output logic [9:0]  lie
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] ecfg;
    logic [31:0] estat;
    logic [31:0] era_q;
    logic [31:0] eentry_q;
    logic [31:0] save [4];

    logic crmd_wen;
    logic prmd_wen;
    logic ecfg_wen;
    logic estat_wen;
    logic era_wen;
    logic eentry_wen;

    // per-register write strobes
    assign crmd_wen   = csr_req.wr_en && (csr_req.waddr == CRMD);
    assign prmd_wen   = csr_req.wr_en && (csr_req.waddr == PRMD);
    assign ecfg_wen   = csr_req.wr_en && (csr_req.waddr == ECFG);
    assign estat_wen  = csr_req.wr_en && (csr_req.waddr == ESTAT);
    assign era_wen    = csr_req.wr_en && (csr_req.waddr == ERA);
    assign eentry_wen = csr_req.wr_en && (csr_req.waddr == EENTRY);

    // crmd takes exception entry over ertn over a software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= CRMD_RESET;
        end else if (flush.excp) begin
            crmd[CRMD_PLV_HI:CRMD_PLV_LO] <= 2'b00;
            crmd[CRMD_IE]                 <= 1'b0;
        end else if (flush.ertn) begin
            crmd[CRMD_PLV_HI:CRMD_PLV_LO] <= prmd[PRMD_PPLV_HI:PRMD_PPLV_LO];
            crmd[CRMD_IE]                 <= prmd[PRMD_PIE];
        end else if (crmd_wen) begin
            crmd <= csr_req.wdata & CRMD_WMASK;
        end
    end

    // prmd saves the interrupted mode on exception entry
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (flush.excp) begin
            prmd[PRMD_PPLV_HI:PRMD_PPLV_LO] <= crmd[CRMD_PLV_HI:CRMD_PLV_LO];
            prmd[PRMD_PIE]                  <= crmd[CRMD_IE];
        end else if (prmd_wen) begin
            prmd <= csr_req.wdata & PRMD_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg <= '0;
        end else if (ecfg_wen) begin
            ecfg <= csr_req.wdata & ECFG_WMASK;
        end
    end

    // hardware pending bits follow the sampled lines every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            estat <= '0;
        end else begin
            estat[ESTAT_IS_HW_HI:ESTAT_IS_HW_LO] <= hw_is;
            if (flush.excp) begin
                estat[ESTAT_ECODE_HI:ESTAT_ECODE_LO]       <= flush.ecode;
                estat[ESTAT_ESUBCODE_HI:ESTAT_ESUBCODE_LO] <= flush.esubcode;
            end else if (estat_wen) begin
                // only the two software interrupt bits are writable
                estat[ESTAT_IS_SW_HI:ESTAT_IS_SW_LO] <=
                    csr_req.wdata[ESTAT_IS_SW_HI:ESTAT_IS_SW_LO];
            end
        end
    end

    // era takes the faulting pc
    always_ff @(posedge clk) begin
        if (flush.excp) begin
            era_q <= flush.era;
        end else if (era_wen) begin
            era_q <= csr_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_q <= '0;
        end else if (eentry_wen) begin
            eentry_q <= csr_req.wdata & EENTRY_WMASK;
        end
    end

    // scratch registers for the handler
    for (genvar i = 0; i < 4; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (csr_req.wr_en && (csr_req.waddr == 14'(SAVE0 + i))) begin
                save[i] <= csr_req.wdata;
            end
        end
    end

    // read port where a same-cycle write wins
    always_comb begin
        if (csr_req.wr_en && (csr_req.waddr == csr_req.raddr)) begin
            rdata = csr_req.wdata;
        end else begin
            case (csr_req.raddr)
                CRMD:    rdata = crmd;
                PRMD:    rdata = prmd;
                ECFG:    rdata = ecfg;
                ESTAT:   rdata = estat;
                ERA:     rdata = era_q;
                EENTRY:  rdata = eentry_q;
                SAVE0:   rdata = save[0];
                SAVE1:   rdata = save[1];
                SAVE2:   rdata = save[2];
                SAVE3:   rdata = save[3];
                // cpuid reads as core 0 like any unmapped address
                default: rdata = '0;
            endcase
        end
    end

    // privilege level as it will be after this cycle
    always_comb begin
        if (flush.excp) begin
            plv = 2'b00;
        end else if (flush.ertn) begin
            plv = prmd[PRMD_PPLV_HI:PRMD_PPLV_LO];
        end else if (crmd_wen) begin
            plv = csr_req.wdata[CRMD_PLV_HI:CRMD_PLV_LO];
        end else begin
            plv = crmd[CRMD_PLV_HI:CRMD_PLV_LO];
        end
    end

    assign eentry = eentry_q;
    assign era    = era_q;
    assign ie     = crmd[CRMD_IE];
    assign is     = estat[ESTAT_IS_HW_HI:ESTAT_IS_SW_LO];
    assign lie    = ecfg[ECFG_LIE_WR_HI:ECFG_LIE_LO];

endmodule

`default_nettype wire

// ==== design/int_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_ctrl (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] interrupt,
    input  logic       ie,
    input  logic [9:0] is,
    input  logic [9:0] lie,
    output logic [7:0] hw_is,
    output logic       has_int
);

    logic [9:0] pending;

    // first sampling stage for the external lines
    always_ff @(posedge clk) begin
        if (reset) begin
            hw_is <= '0;
        end else begin
            hw_is <= interrupt;
        end
    end

    // sources that are both raised and locally enabled
    assign pending = is & lie;

    // global enable gates the whole set
    assign has_int = ie & (|pending);

endmodule

`default_nettype wire

// ==== design/excp_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module excp_ctrl
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  excp_req_t   excp_req,
    input  logic        ertn,
    input  logic [31:0] eentry,
    input  logic [31:0] era,
    output flush_t      flush,
    output redirect_t   redirect
);

    logic        take_excp;
    logic        take_ertn;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic [31:0] target;

    // exception wins and a colliding ertn is dropped
    assign take_excp = excp_req.valid;
    assign take_ertn = ertn & ~excp_req.valid;

    always_comb begin
        flush.excp     = take_excp;
        flush.ertn     = take_ertn;
        flush.era      = excp_req.pc;
        flush.ecode    = excp_req.ecode;
        flush.esubcode = excp_req.esubcode;
    end

    // handler base for exceptions, saved pc for ertn
    assign target = take_excp ? (eentry & EENTRY_WMASK) : era;

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take_excp | take_ertn;
        end
    end

    always_ff @(posedge clk) begin
        if (take_excp || take_ertn) begin
            redirect_pc <= target;
        end
    end

    assign redirect.valid = redirect_valid;
    assign redirect.pc    = redirect_pc;

endmodule

`default_nettype wire

// ==== design/csr_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_req_t    csr_req,
    input  excp_req_t   excp_req,
    input  logic        ertn,
    input  logic [7:0]  interrupt,
    output logic [31:0] rdata,
    output logic [1:0]  plv,
    output logic        has_int,
    output redirect_t   redirect
);

    flush_t      flush;
    logic [31:0] eentry;
    logic [31:0] era;
    logic [7:0]  hw_is;
    logic        ie;
    logic [9:0]  is;
    logic [9:0]  lie;

    csr_regfile csr_regfile_inst (
        .clk     (clk),
        .reset   (reset),
        .csr_req (csr_req),
        .flush   (flush),
        .hw_is   (hw_is),
        .rdata   (rdata),
        .plv     (plv),
        .eentry  (eentry),
        .era     (era),
        .ie      (ie),
        .is      (is),
        .lie     (lie)
    );

    int_ctrl int_ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .interrupt (interrupt),
        .ie        (ie),
        .is        (is),
        .lie       (lie),
        .hw_is     (hw_is),
        .has_int   (has_int)
    );

    excp_ctrl excp_ctrl_inst (
        .clk      (clk),
        .reset    (reset),
        .excp_req (excp_req),
        .ertn     (ertn),
        .eentry   (eentry),
        .era      (era),
        .flush    (flush),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

// ==== verification/csr_unit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assert
    import csr_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input flush_t      flush,
    input logic [31:0] era,
    input redirect_t   redirect
);

    // redirect is a single-cycle strobe
    redirect_pulse: assert property (
        @(posedge clk) disable iff (reset) redirect.valid |=> !redirect.valid
    ) else $error("redirect.valid held high for more than one cycle");

    // exception entry saves the faulting pc over any era write
    era_capture: assert property (
        @(posedge clk) disable iff (reset) flush.excp |=> era == $past(flush.era)
    ) else $error("era does not hold the pc of the exception");

    // redirect register clears under reset
    redirect_reset: assert property (
        @(posedge clk) reset |=> !redirect.valid
    ) else $error("redirect.valid high after a reset cycle");

endmodule

bind csr_unit_top csr_unit_assert csr_unit_assert_inst (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .era      (era),
    .redirect (redirect)
);

`default_nettype wire

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
();

    typedef enum logic [2:0] {K_WRITE, K_READ, K_EXCP, K_ERTN, K_INT} kind_e;

    // rnd selects random data on writes and the model value on reads
    // exception rows carry esubcode in addr and pc in data
    typedef struct packed {
        kind_e       kind;
        logic [13:0] addr;
        logic [31:0] data;
        ecode_e      ecode;
        logic [31:0] exp;
        bit          rnd;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    csr_req_t    csr_req;
    excp_req_t   excp_req;
    logic        ertn;
    logic [7:0]  interrupt;
    logic [31:0] rdata;
    logic [1:0]  plv;
    logic        has_int;
    redirect_t   redirect;

    row_t        rows[$];
    logic [31:0] lfsr = 32'd20835;

    // reference copies of the CSRs
    logic [31:0] m_crmd = 32'h8;
    logic [31:0] m_prmd = 32'h0;
    logic [31:0] m_ecfg = 32'h0;
    logic [31:0] m_estat = 32'h0;
    logic [31:0] m_era;
    logic [31:0] m_eentry = 32'h0;
    logic [31:0] m_save [4];

    csr_unit_top csr_unit_top_inst (
        .clk       (clk),
        .reset     (reset),
        .csr_req   (csr_req),
        .excp_req  (excp_req),
        .ertn      (ertn),
        .interrupt (interrupt),
        .rdata     (rdata),
        .plv       (plv),
        .has_int   (has_int),
        .redirect  (redirect)
    );

    always #50 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = 32'h0;
        for (int i = 0; i < 32; i++) begin
            lfsr = next_lfsr(lfsr);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] expected_csr(input logic [13:0] addr);
        case (addr)
            CRMD:    return m_crmd;
            PRMD:    return m_prmd;
            ECFG:    return m_ecfg;
            ESTAT:   return m_estat;
            ERA:     return m_era;
            EENTRY:  return m_eentry;
            SAVE0, SAVE1, SAVE2, SAVE3: return m_save[addr[1:0]];
            default: return 32'h0;
        endcase
    endfunction

    // only the writable fields take the data
    function automatic void write_model(input logic [13:0] addr, input logic [31:0] data);
        case (addr)
            CRMD:    m_crmd = data & 32'h0000_01FF;
            PRMD:    m_prmd = data & 32'h0000_0007;
            ECFG:    m_ecfg = data & 32'h0000_03FF;
            ESTAT:   m_estat[1:0] = data[1:0];
            ERA:     m_era = data;
            EENTRY:  m_eentry = data & 32'hFFFF_FFC0;
            SAVE0, SAVE1, SAVE2, SAVE3: m_save[addr[1:0]] = data;
            default: ;
        endcase
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Finished with errors");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    // drop the strobe, then expect the redirect on the next edge only
    task automatic await_redirect(input logic [31:0] exp_pc);
        int n;
        @(posedge clk);
        excp_req.valid <= 1'b0;
        ertn           <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!redirect.valid) begin
            n++;
            if (n > 8) begin
                timeout_fail("redirect");
            end
            @(negedge clk);
        end
        check(n, 32'h0, "redirect delay");
        check(redirect.pc, exp_pc, "redirect pc");
        @(negedge clk);
        check(32'(redirect.valid), 32'h0, "redirect width");
    endtask

    task automatic settle_has_int(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (has_int !== level) begin
            n++;
            if (n > 10) begin
                timeout_fail("has_int");
            end
            @(negedge clk);
        end
        // low must hold past the two-stage sampling delay
        if (!level) begin
            for (int k = 0; k < 4; k++) begin
                @(negedge clk);
                check(32'(has_int), 32'h0, "has_int stays low");
            end
        end
    endtask

    function automatic void add_row(input kind_e kind, input logic [13:0] addr,
                                    input logic [31:0] data, input ecode_e ecode,
                                    input logic [31:0] exp, input bit rnd);
        row_t r;
        r.kind  = kind;
        r.addr  = addr;
        r.data  = data;
        r.ecode = ecode;
        r.exp   = exp;
        r.rnd   = rnd;
        rows.push_back(r);
    endfunction

    task automatic apply_row(input row_t r);
        logic [31:0] data;
        logic [31:0] exp;
        logic [1:0]  exp_plv;
        if (r.kind == K_WRITE && r.rnd) begin
            data = rand_word();
        end else begin
            data = r.data;
        end
        if (r.kind == K_WRITE) begin
            exp = data;
        end else begin
            exp = r.rnd ? expected_csr(r.addr) : r.exp;
        end
        exp_plv = (r.kind == K_WRITE && r.addr == CRMD) ? data[1:0] : m_crmd[1:0];
        @(posedge clk);
        csr_req.wr_en  <= 1'b0;
        excp_req.valid <= 1'b0;
        ertn           <= 1'b0;
        case (r.kind)
            K_WRITE: begin
                csr_req.wr_en <= 1'b1;
                csr_req.waddr <= r.addr;
                csr_req.wdata <= data;
                csr_req.raddr <= r.addr;
            end
            K_READ: begin
                csr_req.raddr <= r.addr;
            end
            K_EXCP: begin
                excp_req.valid    <= 1'b1;
                excp_req.ecode    <= r.ecode;
                excp_req.esubcode <= r.addr[8:0];
                excp_req.pc       <= data;
            end
            K_ERTN: begin
                ertn <= 1'b1;
            end
            default: begin
                interrupt <= data[7:0];
            end
        endcase
        case (r.kind)
            K_WRITE, K_READ: begin
                @(negedge clk);
                check(rdata, exp, "rdata");
                check(32'(plv), 32'(exp_plv), "plv");
                if (r.kind == K_WRITE) begin
                    write_model(r.addr, data);
                end
            end
            K_EXCP: begin
                @(negedge clk);
                check(32'(plv), 32'h0, "plv on exception");
                m_prmd[2:0]    = m_crmd[2:0];
                m_crmd[2:0]    = 3'b000;
                m_era          = data;
                m_estat[21:16] = r.ecode;
                m_estat[30:22] = r.addr[8:0];
                await_redirect(r.exp);
            end
            K_ERTN: begin
                @(negedge clk);
                check(32'(plv), 32'(m_prmd[1:0]), "plv on ertn");
                m_crmd[2:0] = m_prmd[2:0];
                await_redirect(r.exp);
            end
            default: begin
                settle_has_int(r.exp[0]);
            end
        endcase
    endtask

    task automatic build_table();
        // reset values, random scratch data, unmapped holes
        add_row(K_READ,  CRMD,     32'h0, INT, 32'h0000_0008, 1'b0);
        add_row(K_READ,  PRMD,     32'h0, INT, 32'h0, 1'b0);
        add_row(K_READ,  ECFG,     32'h0, INT, 32'h0, 1'b0);
        add_row(K_READ,  ESTAT,    32'h0, INT, 32'h0, 1'b0);
        add_row(K_READ,  EENTRY,   32'h0, INT, 32'h0, 1'b0);
        add_row(K_READ,  CPUID,    32'h0, INT, 32'h0, 1'b0);
        add_row(K_WRITE, SAVE0,    32'h0, INT, 32'h0, 1'b1);
        add_row(K_READ,  SAVE0,    32'h0, INT, 32'h0, 1'b1);
        add_row(K_WRITE, SAVE1,    32'h0, INT, 32'h0, 1'b1);
        add_row(K_READ,  SAVE1,    32'h0, INT, 32'h0, 1'b1);
        add_row(K_WRITE, SAVE2,    32'h0, INT, 32'h0, 1'b1);
        add_row(K_READ,  SAVE2,    32'h0, INT, 32'h0, 1'b1);
        add_row(K_WRITE, SAVE3,    32'h0, INT, 32'h0, 1'b1);
        add_row(K_READ,  SAVE3,    32'h0, INT, 32'h0, 1'b1);
        add_row(K_WRITE, ERA,      32'h0, INT, 32'h0, 1'b1);
        add_row(K_READ,  ERA,      32'h0, INT, 32'h0, 1'b1);
        add_row(K_READ,  14'h0007, 32'h0, INT, 32'h0, 1'b0);
        add_row(K_READ,  14'h3FFF, 32'h0, INT, 32'h0, 1'b0);
        // write masks
        add_row(K_WRITE, CRMD,   32'hFFFF_FFFF, INT, 32'h0, 1'b0);
        add_row(K_READ,  CRMD,   32'h0, INT, 32'h0000_01FF, 1'b0);
        add_row(K_WRITE, PRMD,   32'hFFFF_FFFF, INT, 32'h0, 1'b0);
        add_row(K_READ,  PRMD,   32'h0, INT, 32'h0000_0007, 1'b0);
        add_row(K_WRITE, ECFG,   32'hFFFF_FFFF, INT, 32'h0, 1'b0);
        add_row(K_READ,  ECFG,   32'h0, INT, 32'h0000_03FF, 1'b0);
        add_row(K_WRITE, EENTRY, 32'hFFFF_FFFF, INT, 32'h0, 1'b0);
        add_row(K_READ,  EENTRY, 32'h0, INT, 32'hFFFF_FFC0, 1'b0);
        add_row(K_WRITE, ESTAT,  32'hFFFF_FFFF, INT, 32'h0, 1'b0);
        add_row(K_READ,  ESTAT,  32'h0, INT, 32'h0000_0003, 1'b0);
        // exception taken from plv 3 with interrupts on
        add_row(K_WRITE, ESTAT,    32'h0, INT, 32'h0, 1'b0);
        add_row(K_WRITE, EENTRY,   32'h1C00_0055, INT, 32'h0, 1'b0);
        add_row(K_READ,  EENTRY,   32'h0, INT, 32'h1C00_0040, 1'b0);
        add_row(K_WRITE, CRMD,     32'h0000_0007, INT, 32'h0, 1'b0);
        add_row(K_EXCP,  14'h0005, 32'h1C00_1234, SYS, 32'h1C00_0040, 1'b0);
        add_row(K_READ,  PRMD,     32'h0, INT, 32'h0000_0007, 1'b0);
        add_row(K_READ,  CRMD,     32'h0, INT, 32'h0, 1'b0);
        add_row(K_READ,  ERA,      32'h0, INT, 32'h1C00_1234, 1'b0);
        add_row(K_READ,  ESTAT,    32'h0, INT, 32'h014B_0000, 1'b0);
        add_row(K_ERTN,  CRMD,     32'h0, INT, 32'h1C00_1234, 1'b0);
        add_row(K_READ,  CRMD,     32'h0, INT, 32'h0000_0007, 1'b0);
        // line 0 sits at IS bit 2
        add_row(K_WRITE, ECFG,  32'h0000_0004, INT, 32'h0, 1'b0);
        add_row(K_INT,   CRMD,  32'h0000_0001, INT, 32'h1, 1'b0);
        add_row(K_INT,   CRMD,  32'h0, INT, 32'h0, 1'b0);
        add_row(K_WRITE, ECFG,  32'h0000_0008, INT, 32'h0, 1'b0);
        add_row(K_INT,   CRMD,  32'h0000_0001, INT, 32'h0, 1'b0);
        add_row(K_INT,   CRMD,  32'h0, INT, 32'h0, 1'b0);
        add_row(K_WRITE, ECFG,  32'h0000_0004, INT, 32'h0, 1'b0);
        add_row(K_WRITE, CRMD,  32'h0000_0003, INT, 32'h0, 1'b0);
        add_row(K_INT,   CRMD,  32'h0000_0001, INT, 32'h0, 1'b0);
        add_row(K_INT,   CRMD,  32'h0, INT, 32'h0, 1'b0);
        // software interrupt bit 0
        add_row(K_WRITE, CRMD,  32'h0000_0004, INT, 32'h0, 1'b0);
        add_row(K_WRITE, ECFG,  32'h0000_0001, INT, 32'h0, 1'b0);
        add_row(K_WRITE, ESTAT, 32'h0000_0001, INT, 32'h0, 1'b0);
        add_row(K_INT,   CRMD,  32'h0, INT, 32'h1, 1'b0);
        add_row(K_WRITE, ESTAT, 32'h0, INT, 32'h0, 1'b0);
        add_row(K_INT,   CRMD,  32'h0, INT, 32'h0, 1'b0);
    endtask

    initial begin
        reset     <= 1'b1;
        csr_req   <= '0;
        excp_req  <= '0;
        ertn      <= 1'b0;
        interrupt <= 8'h00;
        build_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/csr_pkg.sv
design/csr_regfile.sv
design/int_ctrl.sv
design/excp_ctrl.sv
design/csr_unit_top.sv
verification/csr_unit_assert.sv
verification/csr_unit_tb.sv

// ==== Makefile ====
SRCS := $(shell cat verilog.f)

run: obj_dir/Vcsr_unit_tb
	./obj_dir/Vcsr_unit_tb

obj_dir/Vcsr_unit_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module csr_unit_tb -f verilog.f

clean:
	rm -rf obj_dir

.PHONY: run clean
